//--- src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	localparam int INSTR_W   = 16;
	localparam int OPCODE_W  = 6;	// Bits 15..10
	localparam int REG_SEL_W = 3;	// rd, rs, rt
	localparam int IMM4_W    = 4;	// imm4 and shamt share bits 3..0
	localparam int IMM7_W    = 7;	// LI immediate
	localparam int IMM10_W   = 10;	// BR offset, CALL target
	localparam int REG_COUNT = 8;
	localparam int SP_REG    = 7;	// r7 is the stack pointer

	// Top two bits give the class
	typedef enum logic [OPCODE_W-1:0] {
		ADD  = 6'b100000,
		ADDI = 6'b100001,
		SUB  = 6'b100010,
		NAND = 6'b100011,
		AND  = 6'b100100,
		ANDI = 6'b100101,
		SRL  = 6'b100110,
		SLL  = 6'b100111,
		XOR  = 6'b101000,
		BR   = 6'b000000,	// PC class
		CALL = 6'b000100,
		RET  = 6'b000101,
		LW   = 6'b001000,	// Memory class
		LI   = 6'b001001,
		POP  = 6'b001010,
		SW   = 6'b001100,
		PUSH = 6'b001110,
		OAMW = 6'b010000,	// Sprite class
		HALT = 6'b011000
	} opcode_t;

	// Second ALU operand
	typedef enum logic [1:0] {
		SRC_RT    = 2'b00,
		SRC_IMM   = 2'b01,
		SRC_SHAMT = 2'b10,
		SRC_NONE  = 2'b11	// Constant one, stack step
	} alu_src_t;

	typedef struct packed {
		logic     call;
		logic     ret;
		logic     branch;
		logic     push_pop;
		logic     pop;
		logic     mem_to_reg;	// Result comes back from memory
		logic     load_imm;
		logic     sign_ext_sel;	// 1 selects sign-extended imm10
		logic     halt;
		alu_src_t alu_src;
		logic     reg_write;
		logic     mem_write;
		logic     mem_read;
		logic     oam_write;
		opcode_t  alu_op;
	} ctrl_t;

endpackage

`default_nettype wire

//--- src/cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

	localparam int ADDR_W    = 8;
	localparam int DATA_W    = 16;
	localparam int MEM_DEPTH = 256;	// Code and data share one array

	localparam logic [ADDR_W-1:0] PROG_LIMIT = 8'h80;	// First data word, code lives below
	localparam logic [ADDR_W-1:0] STACK_BASE = 8'hC0;	// Stack grows upward from here

	// Listed from highest to lowest priority
	typedef enum logic [1:0] {
		REQ_LOAD,
		REQ_DATA,
		REQ_FETCH
	} requester_t;

endpackage

`default_nettype wire

//--- src/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if import cpu_mem_pkg::*; ();

	logic              req;		// Held with addr and wdata until gnt
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              gnt;		// One cycle, access accepted
	logic              rvalid;	// Read data, one cycle after gnt
	logic [DATA_W-1:0] rdata;

	modport requester (output req, we, addr, wdata, input gnt, rvalid, rdata);
	modport memory (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

//--- src/control_logic.sv
`timescale 1ns/1ns
`default_nettype none

module control_logic import cpu_isa_pkg::*; (
	input  opcode_t opcode,
	output ctrl_t   ctrl
);

	always_comb begin
		ctrl         = '0;	// Unknown codes stay all-inactive
		ctrl.alu_op  = ADD;
		ctrl.alu_src = SRC_RT;

		// ALU class, only the defined codes write back
		if (opcode[5]) begin
			if (!opcode[4] && (!opcode[3] || opcode[2:0] == 3'b000)) begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = opcode;
				if (!opcode[1])
					ctrl.alu_src = opcode[0] ? SRC_IMM : SRC_RT;	// ADDI, ANDI take imm4
				else
					ctrl.alu_src = opcode[2] ? SRC_SHAMT : SRC_RT;	// SRL, SLL take shamt
			end
		end

		// PC class
		else if (opcode[5:3] == 3'b000) begin
			if (opcode[2:0] == 3'b000) begin		// BR, pc+1 plus offset through the ALU
				ctrl.branch       = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.alu_src      = SRC_IMM;
			end
			else if (opcode[2:1] == 2'b10) begin	// CALL, RET move the SP by one
				ctrl.reg_write    = 1'b1;
				ctrl.alu_src      = SRC_NONE;
				if (!opcode[0]) begin
					ctrl.call      = 1'b1;	// Return address goes to the stack
					ctrl.mem_write = 1'b1;
				end
				else begin
					ctrl.ret        = 1'b1;	// New pc comes from the stack
					ctrl.mem_read   = 1'b1;
					ctrl.mem_to_reg = 1'b1;
					ctrl.alu_op     = SUB;
				end
			end
		end

		// Memory class
		else if (opcode[5:3] == 3'b001) begin
			if (!opcode[2]) begin
				case (opcode[1:0])
					2'b00: begin	// LW, rs plus imm4
						ctrl.reg_write  = 1'b1;
						ctrl.mem_read   = 1'b1;
						ctrl.mem_to_reg = 1'b1;
						ctrl.alu_src    = SRC_IMM;
					end
					2'b01: begin	// LI, no memory traffic
						ctrl.reg_write = 1'b1;
						ctrl.load_imm  = 1'b1;
					end
					2'b10: begin	// POP
						ctrl.reg_write  = 1'b1;
						ctrl.mem_read   = 1'b1;
						ctrl.mem_to_reg = 1'b1;
						ctrl.push_pop   = 1'b1;
						ctrl.pop        = 1'b1;
						ctrl.alu_src    = SRC_NONE;
						ctrl.alu_op     = SUB;	// SP - 1
					end
					default: ;
				endcase
			end
			else if (opcode[1:0] == 2'b00) begin	// SW
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = SRC_IMM;
			end
			else if (opcode[1:0] == 2'b10) begin	// PUSH
				ctrl.mem_write = 1'b1;
				ctrl.reg_write = 1'b1;		// SP + 1
				ctrl.push_pop  = 1'b1;
				ctrl.alu_src   = SRC_NONE;
			end
		end

		// Sprite class
		else if (opcode[5:4] == 2'b01 && opcode[2:0] == 3'b000) begin
			ctrl.oam_write = !opcode[3];
			ctrl.halt      = opcode[3];
		end
	end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import cpu_mem_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  logic              redirect,
	input  logic [ADDR_W-1:0] redirect_pc,
	input  logic              instr_take,
	output logic              instr_valid,
	output logic [DATA_W-1:0] instr_word,
	mem_port_if.requester     mem
);

	logic              active;		// Set by the first start
	logic [ADDR_W-1:0] fetch_ptr;
	logic [DATA_W-1:0] queue [2];
	logic              head;
	logic [1:0]        count;		// Queue entries
	logic [1:0]        inflight;	// Granted, rvalid not yet seen
	logic [1:0]        inflight_next;
	logic [1:0]        stale;		// In-flight reads from before a flush
	logic              flush;
	logic              keep;		// Return that belongs in the queue

	assign flush = start | redirect;
	assign keep  = mem.rvalid && (stale == 2'd0);

	// Never more than two words owed to the queue
	assign mem.req   = active && ((count + inflight) < 2'd2);
	assign mem.we    = 1'b0;
	assign mem.addr  = fetch_ptr;
	assign mem.wdata = '0;

	assign inflight_next = inflight + {1'b0, mem.gnt} - {1'b0, mem.rvalid};

	assign instr_valid = (count != 2'd0);
	assign instr_word  = queue[head];

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			fetch_ptr <= '0;
			head      <= 1'b0;
			count     <= 2'd0;
			inflight  <= 2'd0;
			stale     <= 2'd0;
		end
		else begin
			inflight <= inflight_next;
			if (start)
				active <= 1'b1;
			if (flush) begin
				fetch_ptr <= start ? '0 : redirect_pc;
				head      <= 1'b0;
				count     <= 2'd0;
				stale     <= inflight_next;	// Whatever is still out is old path
			end
			else begin
				if (mem.gnt)
					fetch_ptr <= fetch_ptr + 1'b1;
				if (mem.rvalid && stale != 2'd0)
					stale <= stale - 1'b1;	// Drop it
				count <= count + {1'b0, keep} - {1'b0, instr_take};
				if (instr_take)
					head <= ~head;
			end
		end
	end

	// Tail slot is head + count
	always_ff @(posedge clk) begin
		if (keep && !flush)
			queue[head ^ count[0]] <= mem.rdata;
	end

endmodule

`default_nettype wire

//--- src/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit import cpu_isa_pkg::*, cpu_mem_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 instr_valid,
	input  logic [INSTR_W-1:0]   instr_word,
	output logic                 instr_take,
	output logic                 redirect,
	output logic [ADDR_W-1:0]    redirect_pc,
	mem_port_if.requester        mem,
	output logic                 oam_we,
	output logic [ADDR_W-1:0]    oam_addr,
	output logic [DATA_W-1:0]    oam_data,
	output logic                 running,
	input  logic [REG_SEL_W-1:0] dbg_sel,
	output logic [DATA_W-1:0]    dbg_data
);

	typedef enum logic [1:0] {IDLE, EXEC, MEM_WAIT, READ_WAIT} state_t;

	state_t               state;
	logic [DATA_W-1:0]    regs [REG_COUNT];
	logic [ADDR_W-1:0]    pc;
	logic [ADDR_W-1:0]    pc_inc;
	opcode_t              opcode;
	ctrl_t                ctrl;
	logic [REG_SEL_W-1:0] rd, rs, rt;
	logic                 go;			// Head instruction taken this cycle
	logic                 stack_op;
	logic [DATA_W-1:0]    imm_ext, alu_a, alu_b, alu_y;
	logic [ADDR_W-1:0]    acc_addr;
	logic [DATA_W-1:0]    acc_wdata;
	logic                 we_q;
	logic [ADDR_W-1:0]    addr_q;
	logic [DATA_W-1:0]    wdata_q;
	logic                 ld_ret;		// Pending read is a return address
	logic [REG_SEL_W-1:0] ld_rd;

	assign opcode = opcode_t'(instr_word[INSTR_W-1 -: OPCODE_W]);

	control_logic dec0 (
		.opcode (opcode),
		.ctrl   (ctrl)
	);

	assign rd       = instr_word[9:7];
	assign rs       = instr_word[6:4];
	assign rt       = instr_word[2:0];
	assign go       = (state == EXEC) && instr_valid;
	assign stack_op = ctrl.push_pop | ctrl.call | ctrl.ret;
	assign pc_inc   = pc + 1'b1;

	assign instr_take = go;
	assign dbg_data   = regs[dbg_sel];

	assign imm_ext = ctrl.sign_ext_sel ?
		{{(DATA_W-IMM10_W){instr_word[IMM10_W-1]}}, instr_word[IMM10_W-1:0]} :
		DATA_W'(instr_word[IMM4_W-1:0]);

	always_comb begin
		if (ctrl.branch)
			alu_a = DATA_W'(pc_inc);	// Branch target
		else if (stack_op)
			alu_a = regs[SP_REG];
		else
			alu_a = regs[rs];
		case (ctrl.alu_src)
			SRC_RT:    alu_b = regs[rt];
			SRC_IMM:   alu_b = imm_ext;
			SRC_SHAMT: alu_b = DATA_W'(instr_word[IMM4_W-1:0]);
			default:   alu_b = DATA_W'(1);
		endcase
	end

	always_comb begin
		case (ctrl.alu_op)
			ADD, ADDI: alu_y = alu_a + alu_b;
			SUB:       alu_y = alu_a - alu_b;
			NAND:      alu_y = ~(alu_a & alu_b);
			AND, ANDI: alu_y = alu_a & alu_b;
			SRL:       alu_y = alu_a >> alu_b[IMM4_W-1:0];
			SLL:       alu_y = alu_a << alu_b[IMM4_W-1:0];
			XOR:       alu_y = alu_a ^ alu_b;
			default:   alu_y = alu_a;
		endcase
	end

	// PUSH and CALL store at the old SP, POP and RET read at the new one
	assign acc_addr  = (ctrl.call || (ctrl.push_pop && !ctrl.pop)) ?
		regs[SP_REG][ADDR_W-1:0] : alu_y[ADDR_W-1:0];
	assign acc_wdata = ctrl.call ? DATA_W'(pc_inc) : (ctrl.push_pop ? regs[rs] : regs[rd]);

	always_comb begin
		redirect    = 1'b0;
		redirect_pc = alu_y[ADDR_W-1:0];
		if (go && (ctrl.branch || ctrl.call)) begin
			redirect    = 1'b1;
			redirect_pc = ctrl.call ? instr_word[ADDR_W-1:0] : alu_y[ADDR_W-1:0];
		end
		else if (state == READ_WAIT && mem.rvalid && ld_ret) begin
			redirect    = 1'b1;	// RET target straight from memory
			redirect_pc = mem.rdata[ADDR_W-1:0];
		end
	end

	assign mem.req   = (state == MEM_WAIT);
	assign mem.we    = we_q;
	assign mem.addr  = addr_q;
	assign mem.wdata = wdata_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			running <= 1'b0;
			oam_we  <= 1'b0;
			pc      <= '0;
			ld_ret  <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= (i == SP_REG) ? DATA_W'(STACK_BASE) : '0;
		end
		else begin
			oam_we <= 1'b0;
			case (state)
				IDLE: if (start) begin
					state   <= EXEC;
					running <= 1'b1;
					pc      <= '0;
				end
				EXEC: if (go) begin
					pc     <= pc_inc;
					ld_ret <= ctrl.ret;
					if (ctrl.branch)
						pc <= alu_y[ADDR_W-1:0];
					if (ctrl.call)
						pc <= instr_word[ADDR_W-1:0];	// Absolute target
					if (ctrl.reg_write && stack_op)
						regs[SP_REG] <= alu_y;
					else if (ctrl.reg_write && !ctrl.mem_to_reg)
						regs[rd] <= ctrl.load_imm ? DATA_W'(instr_word[IMM7_W-1:0]) : alu_y;
					oam_we <= ctrl.oam_write;
					if (ctrl.mem_read || ctrl.mem_write)
						state <= MEM_WAIT;
					if (ctrl.halt) begin
						state   <= IDLE;
						running <= 1'b0;
					end
				end
				MEM_WAIT: if (mem.gnt)
					state <= we_q ? EXEC : READ_WAIT;
				READ_WAIT: if (mem.rvalid) begin
					if (ld_ret)
						pc <= mem.rdata[ADDR_W-1:0];
					else
						regs[ld_rd] <= mem.rdata;	// LW, POP
					state <= EXEC;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (go) begin
			we_q    <= ctrl.mem_write;
			addr_q  <= acc_addr;
			wdata_q <= acc_wdata;
			ld_rd   <= rd;
		end
		if (go && ctrl.oam_write) begin
			oam_addr <= regs[rs][ADDR_W-1:0];
			oam_data <= regs[rt];
		end
	end

endmodule

`default_nettype wire

//--- src/shared_memory.sv
`timescale 1ns/1ns
`default_nettype none

module shared_memory import cpu_mem_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	mem_port_if.memory load_port,
	mem_port_if.memory data_port,
	mem_port_if.memory fetch_port
);

	logic [DATA_W-1:0] mem_array [MEM_DEPTH];
	requester_t        sel;
	requester_t        rd_owner;		// Port waiting on rdata_q
	logic              any_req;
	logic              sel_we;
	logic [ADDR_W-1:0] sel_addr;
	logic [DATA_W-1:0] sel_wdata;
	logic              wr_ok;
	logic              rd_pending;
	logic [DATA_W-1:0] rdata_q;

	// Fixed priority, load over data over fetch
	always_comb begin
		any_req   = 1'b1;
		sel       = REQ_FETCH;
		sel_we    = fetch_port.we;
		sel_addr  = fetch_port.addr;
		sel_wdata = fetch_port.wdata;
		if (load_port.req) begin
			sel       = REQ_LOAD;
			sel_we    = load_port.we;
			sel_addr  = load_port.addr;
			sel_wdata = load_port.wdata;
		end
		else if (data_port.req) begin
			sel       = REQ_DATA;
			sel_we    = data_port.we;
			sel_addr  = data_port.addr;
			sel_wdata = data_port.wdata;
		end
		else
			any_req = fetch_port.req;
	end

	assign load_port.gnt  = any_req && (sel == REQ_LOAD);
	assign data_port.gnt  = any_req && (sel == REQ_DATA);
	assign fetch_port.gnt = any_req && (sel == REQ_FETCH);

	assign wr_ok = (sel != REQ_DATA) || (sel_addr >= PROG_LIMIT);	// Program area is read-only to stores

	always_ff @(posedge clk) begin
		if (any_req && sel_we && wr_ok)
			mem_array[sel_addr] <= sel_wdata;
		rdata_q <= mem_array[sel_addr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pending <= 1'b0;
			rd_owner   <= REQ_FETCH;
		end
		else begin
			rd_pending <= any_req && !sel_we;
			rd_owner   <= sel;
		end
	end

	assign load_port.rvalid  = rd_pending && (rd_owner == REQ_LOAD);
	assign data_port.rvalid  = rd_pending && (rd_owner == REQ_DATA);
	assign fetch_port.rvalid = rd_pending && (rd_owner == REQ_FETCH);
	assign load_port.rdata   = rdata_q;
	assign data_port.rdata   = rdata_q;
	assign fetch_port.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- src/game_cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module game_cpu_top (
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        prog_we,
	input  logic [7:0]  prog_addr,
	input  logic [15:0] prog_data,
	output logic        running,
	output logic        oam_we,
	output logic [7:0]  oam_addr,
	output logic [15:0] oam_data,
	input  logic [2:0]  dbg_sel,
	output logic [15:0] dbg_data
);

	mem_port_if load_if ();
	mem_port_if data_if ();
	mem_port_if fetch_if ();

	logic        instr_valid;
	logic        instr_take;
	logic [15:0] instr_word;
	logic        redirect;
	logic [7:0]  redirect_pc;
	logic        fetch_start;	// Start only counts while halted

	// Load strobe, granted the same cycle by priority
	assign load_if.req   = prog_we && !running;
	assign load_if.we    = 1'b1;
	assign load_if.addr  = prog_addr;
	assign load_if.wdata = prog_data;

	assign fetch_start = start && !running;

	fetch_unit fetch0 (
		.clk         (clk),
		.reset       (reset),
		.start       (fetch_start),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.instr_take  (instr_take),
		.instr_valid (instr_valid),
		.instr_word  (instr_word),
		.mem         (fetch_if)
	);

	execute_unit exec0 (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.instr_valid (instr_valid),
		.instr_word  (instr_word),
		.instr_take  (instr_take),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.mem         (data_if),
		.oam_we      (oam_we),
		.oam_addr    (oam_addr),
		.oam_data    (oam_data),
		.running     (running),
		.dbg_sel     (dbg_sel),
		.dbg_data    (dbg_data)
	);

	shared_memory mem0 (
		.clk        (clk),
		.reset      (reset),
		.load_port  (load_if),
		.data_port  (data_if),
		.fetch_port (fetch_if)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;	// Released on a falling edge, like the other inputs
	end

endmodule

`default_nettype wire

//--- tests/game_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module game_cpu_tb import cpu_isa_pkg::*; ();

	localparam int N_RUNS      = 3;		// Programs per random test
	localparam int ALU_LEN     = 40;
	localparam int MEM_SLOTS   = 30;	// A slot is one instruction or a three-word access
	localparam int SPR_LEN     = 24;
	localparam int STACK_WORDS = 17;
	localparam int RUN_INSTR   = ALU_LEN + 1 + 3 * MEM_SLOTS + 1 + STACK_WORDS + 4 + SPR_LEN + 1;
	localparam int TOTAL_INSTR = N_RUNS * RUN_INSTR;
	localparam int LOAD_CYCLES = TOTAL_INSTR + N_RUNS * (64 + 4 * 24) + 20;	// Loads, readouts
	localparam longint LIMIT_NS = longint'(TOTAL_INSTR * 12 + LOAD_CYCLES) * 100;

	logic        clk;
	logic        reset;
	logic        start;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [15:0] prog_data;
	logic        running;
	logic        oam_we;
	logic [7:0]  oam_addr;
	logic [15:0] oam_data;
	logic [2:0]  dbg_sel;
	logic [15:0] dbg_data;

	logic [31:0] lfsr = 32'hb854;
	logic [15:0] prog [$];			// Program being built
	logic [15:0] m_regs [8];		// ISA model state
	logic [15:0] model_mem [256];
	logic [23:0] m_oam [$];			// {addr, data} per expected OAM write
	logic [23:0] oam_seen [$];
	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	int          e;

	tb_clock_gen clk_gen0 (
		.clk   (clk),
		.reset (reset)
	);

	game_cpu_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.running   (running),
		.oam_we    (oam_we),
		.oam_addr  (oam_addr),
		.oam_data  (oam_data),
		.dbg_sel   (dbg_sel),
		.dbg_data  (dbg_data)
	);

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [2:0] low_reg();
		return 3'(rand_bits(3) % 6);	// r0..r5, keeps r6 and r7 free
	endfunction

	// One ALU-class instruction or LI
	function automatic logic [15:0] random_alu(input bit low_rd);
		logic [5:0] op;
		logic [2:0] rd;
		case (4'(rand_bits(4) % 10))
			4'd0: op = ADD;
			4'd1: op = ADDI;
			4'd2: op = SUB;
			4'd3: op = NAND;
			4'd4: op = AND;
			4'd5: op = ANDI;
			4'd6: op = SRL;
			4'd7: op = SLL;
			4'd8: op = XOR;
			default: op = LI;
		endcase
		rd = low_rd ? low_reg() : 3'(rand_bits(3));
		return {op, rd, 7'(rand_bits(7))};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED time=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic store_word(input logic [7:0] addr, input logic [15:0] data);
		if (addr >= 8'h80)
			model_mem[addr] = data;	// Program area ignores stores
	endtask

	// ISA interpreter from pc 0 up to HALT
	task automatic model_run();
		logic [15:0] w;
		logic [7:0]  pc;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [2:0]  rt;
		logic [3:0]  k;
		logic        halted;
		int          n;
		pc     = 8'd0;
		halted = 1'b0;
		n      = 0;
		m_oam.delete();
		while (!halted && n < 1000) begin
			w  = model_mem[pc];
			rd = w[9:7];
			rs = w[6:4];
			rt = w[2:0];
			k  = w[3:0];
			pc = pc + 8'd1;
			n++;
			case (w[15:10])
				ADD:  m_regs[rd] = m_regs[rs] + m_regs[rt];
				ADDI: m_regs[rd] = m_regs[rs] + 16'(k);
				SUB:  m_regs[rd] = m_regs[rs] - m_regs[rt];
				NAND: m_regs[rd] = ~(m_regs[rs] & m_regs[rt]);
				AND:  m_regs[rd] = m_regs[rs] & m_regs[rt];
				ANDI: m_regs[rd] = m_regs[rs] & 16'(k);
				SRL:  m_regs[rd] = m_regs[rs] >> k;
				SLL:  m_regs[rd] = m_regs[rs] << k;
				XOR:  m_regs[rd] = m_regs[rs] ^ m_regs[rt];
				LI:   m_regs[rd] = 16'(w[6:0]);
				LW:   m_regs[rd] = model_mem[8'(m_regs[rs] + 16'(k))];
				SW:   store_word(8'(m_regs[rs] + 16'(k)), m_regs[rd]);
				PUSH: begin
					store_word(m_regs[7][7:0], m_regs[rs]);
					m_regs[7] = m_regs[7] + 16'd1;
				end
				POP: begin
					m_regs[7]  = m_regs[7] - 16'd1;
					m_regs[rd] = model_mem[m_regs[7][7:0]];
				end
				CALL: begin
					store_word(m_regs[7][7:0], 16'(pc));	// Return address
					m_regs[7] = m_regs[7] + 16'd1;
					pc        = w[7:0];
				end
				RET: begin
					m_regs[7] = m_regs[7] - 16'd1;
					pc        = model_mem[m_regs[7][7:0]][7:0];
				end
				BR:   pc = pc + w[7:0];	// Low byte of the sign-extended offset
				OAMW: m_oam.push_back({m_regs[rs][7:0], m_regs[rt]});
				HALT: halted = 1'b1;
				default: ;
			endcase
		end
		if (!halted) begin
			$display("%0t model ran 1000 steps without reaching HALT", $time);
			errors++;
		end
	endtask

	task automatic load_word(input logic [7:0] addr, input logic [15:0] data);
		@(negedge clk);
		prog_we   = 1'b1;
		prog_addr = addr;
		prog_data = data;
		model_mem[addr] = data;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++)
			load_word(8'(i), prog[i]);
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	// Pattern over the whole address
	task automatic preload_data();
		for (int a = 8'h80; a < 8'hC0; a++)
			load_word(8'(a), {8'(a), ~8'(a)} ^ 16'h3c5a);
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	task automatic run_program();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		checks++;
		if (running !== 1'b1) begin
			$display("%0t running did not rise after start", $time);
			errors++;
		end
		while (running === 1'b1)
			@(negedge clk);	// Watchdog covers a stuck core
		@(negedge clk);
		model_run();
	endtask

	task automatic check_regs();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			dbg_sel = 3'(i);
			#10;
			check_value($sformatf("dbg_data[r%0d]", i), dbg_data, m_regs[i]);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("%0t test %s done, no errors", $time, name);
		else begin
			tests_failed++;
			$display("%0t test %s done, %0d errors", $time, name, errors - errs_before);
		end
	endtask

	always @(negedge clk)
		if (oam_we === 1'b1)
			oam_seen.push_back({oam_addr, oam_data});

	initial begin
		#(LIMIT_NS);
		$display("%0t watchdog expired, the tests did not finish in time", $time);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		start     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = 8'd0;
		prog_data = 16'd0;
		dbg_sel   = 3'd0;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 8; i++)
			m_regs[i] = (i == 7) ? 16'h00C0 : 16'h0000;	// Stack base in r7
		wait (reset === 1'b0);

		// Idle after reset
		e = errors;
		repeat (5) begin
			@(negedge clk);
			check_value("running", 16'(running), 16'd0);
			check_value("oam_we", 16'(oam_we), 16'd0);
		end
		check_regs();
		report_test("reset state", e);

		e = errors;
		repeat (N_RUNS) begin
			prog.delete();
			repeat (ALU_LEN) prog.push_back(random_alu(1'b0));
			prog.push_back({HALT, 10'd0});
			load_program();
			run_program();
			check_regs();
		end
		report_test("random alu", e);

		// Base in r6, doubled so 0x80..0xBF after imm4
		e = errors;
		repeat (N_RUNS) begin
			prog.delete();
			repeat (MEM_SLOTS) begin
				case (2'(rand_bits(2)))
					2'd2: begin
						prog.push_back({LI, 3'd6, 7'(8'h40 + rand_bits(4) + rand_bits(3))});
						prog.push_back({ADD, 3'd6, 3'd6, 1'b0, 3'd6});
						prog.push_back({SW, 3'(rand_bits(3)), 3'd6, 4'(rand_bits(4))});
					end
					2'd3: begin
						prog.push_back({LI, 3'd6, 7'(8'h40 + rand_bits(4) + rand_bits(3))});
						prog.push_back({ADD, 3'd6, 3'd6, 1'b0, 3'd6});
						prog.push_back({LW, low_reg(), 3'd6, 4'(rand_bits(4))});
					end
					default: prog.push_back(random_alu(1'b1));
				endcase
			end
			prog.push_back({HALT, 10'd0});
			preload_data();
			load_program();
			run_program();
			check_regs();
		end
		report_test("random memory", e);

		e = errors;
		repeat (N_RUNS) begin
			prog.delete();
			prog.push_back({LI, 3'd7, 7'h60});
			prog.push_back({ADD, 3'd7, 3'd7, 1'b0, 3'd7});	// SP back to 0xC0
			prog.push_back({LI, 3'd1, 7'(rand_bits(7))});
			prog.push_back({LI, 3'd2, 7'(rand_bits(7))});
			prog.push_back({PUSH, 3'd0, 3'd1, 4'd0});
			prog.push_back({PUSH, 3'd0, 3'd2, 4'd0});
			prog.push_back({CALL, 10'd14});
			prog.push_back({BR, 10'd3});				// Lands on 11
			repeat (3) prog.push_back({LI, low_reg(), 7'(rand_bits(7))});	// Skipped
			prog.push_back({POP, 3'd5, 7'd0});
			prog.push_back({POP, 3'd4, 7'd0});
			prog.push_back({HALT, 10'd0});
			prog.push_back(random_alu(1'b1));			// Subroutine at 14
			prog.push_back(random_alu(1'b1));
			prog.push_back({RET, 10'd0});
			load_program();
			run_program();
			check_regs();
		end
		report_test("stack and flow", e);

		e = errors;
		repeat (N_RUNS) begin
			prog.delete();
			repeat (4) prog.push_back({LI, 3'(rand_bits(3)), 7'(rand_bits(7))});
			repeat (SPR_LEN) begin
				if (rand_bits(1) != 0)
					prog.push_back({OAMW, 10'(rand_bits(10))});
				else
					prog.push_back(random_alu(1'b0));
			end
			prog.push_back({HALT, 10'd0});
			load_program();
			oam_seen.delete();
			run_program();
			checks++;
			if (oam_seen.size() != m_oam.size()) begin
				$display("%0t sprite program gave %0d OAM writes, the model expects %0d",
					$time, oam_seen.size(), m_oam.size());
				errors++;
			end
			else begin
				for (int i = 0; i < m_oam.size(); i++) begin
					check_value($sformatf("oam_addr[%0d]", i),
						16'(oam_seen[i][23:16]), 16'(m_oam[i][23:16]));
					check_value($sformatf("oam_data[%0d]", i), oam_seen[i][15:0], m_oam[i][15:0]);
				end
			end
			check_regs();
		end
		report_test("sprite writes", e);

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/cpu_isa_pkg.sv
src/cpu_mem_pkg.sv
src/mem_port_if.sv
src/control_logic.sv
src/fetch_unit.sv
src/execute_unit.sv
src/shared_memory.sv
src/game_cpu_top.sv
tests/tb_clock_gen.sv
tests/game_cpu_tb.sv
